// File: list.f
mdu_pkg.sv
mdu_ctrl.sv
mdu_operand_prep.sv
mdu_iter_core.sv
mdu_result_fix.sv
mdu_top.sv
tb_mdu.sv

// File: mdu_ctrl.sv
// ------------------------------
// FSM for the iterative unit; one operation in flight at a time
// WIDTH must be a power of two, the step counter is log2(WIDTH) bits
// ------------------------------
`timescale 1ns/1ps

module mdu_ctrl
  import mdu_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic    clk,
  input  logic    reset,
  input  mdu_fn_e req_fn,
  input  logic    req_val,
  output logic    req_rdy,
  output logic    resp_val,
  input  logic    resp_rdy,
  output logic    load,
  output logic    step,
  output logic    div_mode
);

  localparam int CNT_W = $clog2(WIDTH);

  mdu_state_e       state;
  mdu_state_e       state_next;
  mdu_fn_e          fn_reg;
  logic [CNT_W-1:0] count;
  logic             resp_go;
  logic             calc_done;

  // ------------------------------
  // Handshake and datapath strobes
  // ------------------------------
  assign req_rdy   = (state == ST_IDLE);
  assign resp_val  = (state == ST_SIGN);
  assign load      = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign step      = (state == ST_CALC);
  assign calc_done = (count == '0);

  // Core initialises on the load edge, so mode comes from the live request in idle
  assign div_mode = (state == ST_IDLE) ? fn_is_div(req_fn) : fn_is_div(fn_reg);

  // ------------------------------
  // State register and next state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: if (load)      state_next = ST_CALC;
      ST_CALC: if (calc_done) state_next = ST_SIGN;
      ST_SIGN: if (resp_go)   state_next = ST_IDLE;
      default:                state_next = ST_IDLE;
    endcase
  end

  // Function and step counter, counts WIDTH-1 down to zero
  always_ff @(posedge clk) begin
    if (load) begin
      fn_reg <= req_fn;
      count  <= CNT_W'(WIDTH - 1);
    end else if (step) begin
      count  <= count - 1'b1;
    end
  end

  // ------------------------------
  // Assertions
  // ------------------------------
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  // Function held during an operation must be one of the five legal codes
  a_fn_legal: assert property (@(posedge clk) disable iff (reset)
    (state != ST_IDLE) |-> (fn_reg inside {FN_MUL, FN_DIV, FN_DIVU, FN_REM, FN_REMU}));

endmodule

// File: mdu_iter_core.sv
// ------------------------------
// Shift-add multiply and restoring divide, one bit per step
// Registers are loaded on load and only change on step
// ------------------------------
`timescale 1ns/1ps

module mdu_iter_core #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               load,
  input  logic               step,
  input  logic               div_mode,
  input  logic [WIDTH-1:0]   abs_a,
  input  logic [WIDTH-1:0]   abs_b,
  output logic [2*WIDTH-1:0] acc_prod,
  output logic [WIDTH-1:0]   quot,
  output logic [WIDTH-1:0]   rem
);

  localparam int RW = 2 * WIDTH + 1;

  // a_reg holds multiplicand, or {remainder, dividend/quotient} when dividing
  logic [RW-1:0]    a_reg;
  logic [WIDTH-1:0] b_reg;
  // Product accumulator, or divisor in the upper half when dividing
  logic [RW-1:0]    res_reg;

  logic [RW-1:0]    a_shift;
  logic [RW-1:0]    sum;
  logic [RW-1:0]    diff;
  logic             diff_neg;

  // ------------------------------
  // Add/subtract
  // ------------------------------
  assign a_shift  = a_reg << 1;
  assign sum      = res_reg + a_reg;
  assign diff     = a_shift - res_reg;
  assign diff_neg = diff[RW-1];

  always_ff @(posedge clk) begin
    if (load) begin
      a_reg <= {{(WIDTH + 1){1'b0}}, abs_a};
      b_reg <= abs_b;
      if (div_mode) begin
        res_reg <= {1'b0, abs_b, {WIDTH{1'b0}}};
      end else begin
        res_reg <= '0;
      end
    end else if (step) begin
      if (div_mode) begin
        // Restore on a negative difference, else keep it with quotient bit 1
        if (diff_neg) begin
          a_reg <= a_shift;
        end else begin
          a_reg <= {diff[RW-1:1], 1'b1};
        end
      end else begin
        if (b_reg[0]) begin
          res_reg <= sum;
        end
        a_reg <= a_shift;
        b_reg <= b_reg >> 1;
      end
    end
  end

  // ------------------------------
  // Raw results
  // ------------------------------
  assign acc_prod = res_reg[2*WIDTH-1:0];
  assign quot     = a_reg[WIDTH-1:0];
  assign rem      = a_reg[2*WIDTH-1:WIDTH];

  // Controller never loads and steps in the same cycle
  a_load_step_excl: assert property (@(posedge clk)
    !((load === 1'b1) && (step === 1'b1)));

endmodule

// File: mdu_operand_prep.sv
// ------------------------------
// Operand magnitudes and result-negation flags
// Flags are valid from the load edge until the next load
// ------------------------------
`timescale 1ns/1ps

module mdu_operand_prep
  import mdu_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             load,
  input  mdu_fn_e          req_fn,
  input  logic [WIDTH-1:0] req_a,
  input  logic [WIDTH-1:0] req_b,
  output logic [WIDTH-1:0] abs_a,
  output logic [WIDTH-1:0] abs_b,
  output logic             neg_low,
  output logic             neg_high
);

  logic is_signed;
  logic sign_a;
  logic sign_b;

  assign is_signed = fn_is_signed(req_fn);
  assign sign_a    = is_signed && req_a[WIDTH-1];
  assign sign_b    = is_signed && req_b[WIDTH-1];

  // Two's complement magnitude; most negative value maps to 2**(WIDTH-1)
  assign abs_a = sign_a ? (~req_a + 1'b1) : req_a;
  assign abs_b = sign_b ? (~req_b + 1'b1) : req_b;

  // ------------------------------
  // Negation flags
  // ------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      // Quotient or product sign
      neg_low <= sign_a ^ sign_b;
      // Remainder takes the dividend sign, product upper half follows low
      if (req_fn == FN_MUL) begin
        neg_high <= sign_a ^ sign_b;
      end else begin
        neg_high <= sign_a;
      end
    end
  end

endmodule

// File: mdu_pkg.sv
// ------------------------------
// Opcode and FSM state types for the multiply/divide unit
// Function codes 5 to 7 are illegal and must not be requested
// ------------------------------

package mdu_pkg;

  // ------------------------------
  // Function opcode
  // ------------------------------
  typedef enum logic [2:0] {
    FN_MUL  = 3'd0,
    FN_DIV  = 3'd1,
    FN_DIVU = 3'd2,
    FN_REM  = 3'd3,
    FN_REMU = 3'd4
  } mdu_fn_e;

  // ------------------------------
  // Controller states
  // ------------------------------
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_SIGN = 2'd2
  } mdu_state_e;

  // Signed functions work on magnitudes and fix signs at the end
  function automatic logic fn_is_signed(mdu_fn_e fn);
    return (fn == FN_MUL) || (fn == FN_DIV) || (fn == FN_REM);
  endfunction

  // DIV and REM share one datapath, as do DIVU and REMU
  function automatic logic fn_is_div(mdu_fn_e fn);
    return (fn == FN_DIV) || (fn == FN_DIVU) || (fn == FN_REM) || (fn == FN_REMU);
  endfunction

endpackage

// File: mdu_result_fix.sv
// ------------------------------
// Sign correction and result packing, purely combinational
// ------------------------------
`timescale 1ns/1ps

module mdu_result_fix #(
  parameter int WIDTH = 32
) (
  input  logic               div_mode,
  input  logic               neg_low,
  input  logic               neg_high,
  input  logic [2*WIDTH-1:0] acc_prod,
  input  logic [WIDTH-1:0]   quot,
  input  logic [WIDTH-1:0]   rem,
  output logic [2*WIDTH-1:0] resp_result
);

  logic [2*WIDTH-1:0] prod_fix;
  logic [WIDTH-1:0]   quot_fix;
  logic [WIDTH-1:0]   rem_fix;

  // Full-width product negation
  assign prod_fix = neg_low ? (~acc_prod + 1'b1) : acc_prod;

  // Quotient and remainder carry separate signs
  assign quot_fix = neg_low  ? (~quot + 1'b1) : quot;
  assign rem_fix  = neg_high ? (~rem + 1'b1)  : rem;

  assign resp_result = div_mode ? {rem_fix, quot_fix} : prod_fix;

endmodule

// File: mdu_top.sv
// ------------------------------
// Iterative multiply/divide unit with valid/ready request and response
// Response arrives WIDTH cycles after the accepting edge
// ------------------------------
`timescale 1ns/1ps

module mdu_top
  import mdu_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  mdu_fn_e            req_fn,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  input  logic               req_val,
  output logic               req_rdy,
  output logic [2*WIDTH-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  logic               load;
  logic               step;
  logic               div_mode;
  logic [WIDTH-1:0]   abs_a;
  logic [WIDTH-1:0]   abs_b;
  logic               neg_low;
  logic               neg_high;
  logic [2*WIDTH-1:0] acc_prod;
  logic [WIDTH-1:0]   quot;
  logic [WIDTH-1:0]   rem;

  mdu_ctrl #(.WIDTH(WIDTH)) u_mdu_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_fn   (req_fn),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step),
    .div_mode (div_mode)
  );

  mdu_operand_prep #(.WIDTH(WIDTH)) u_mdu_operand_prep (
    .clk      (clk),
    .load     (load),
    .req_fn   (req_fn),
    .req_a    (req_a),
    .req_b    (req_b),
    .abs_a    (abs_a),
    .abs_b    (abs_b),
    .neg_low  (neg_low),
    .neg_high (neg_high)
  );

  mdu_iter_core #(.WIDTH(WIDTH)) u_mdu_iter_core (
    .clk      (clk),
    .load     (load),
    .step     (step),
    .div_mode (div_mode),
    .abs_a    (abs_a),
    .abs_b    (abs_b),
    .acc_prod (acc_prod),
    .quot     (quot),
    .rem      (rem)
  );

  mdu_result_fix #(.WIDTH(WIDTH)) u_mdu_result_fix (
    .div_mode    (div_mode),
    .neg_low     (neg_low),
    .neg_high    (neg_high),
    .acc_prod    (acc_prod),
    .quot        (quot),
    .rem         (rem),
    .resp_result (resp_result)
  );

endmodule

// File: tb_mdu.sv
// ------------------------------
// Self-checking testbench for mdu_top at WIDTH 32
// Random operands come from $urandom with seed 4
// ------------------------------
`timescale 1ns/1ps

module tb_mdu
  import mdu_pkg::*;
();

  localparam int WIDTH   = 32;
  localparam int LATENCY = 32;
  localparam int TIMEOUT = 200;

  logic               clk;
  logic               reset;
  mdu_fn_e            req_fn;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  logic               req_val;
  logic               req_rdy;
  logic [2*WIDTH-1:0] resp_result;
  logic               resp_val;
  logic               resp_rdy;

  // Expected responses in request order
  logic [2*WIDTH-1:0] exp_q[$];
  mdu_fn_e            fn_q[$];
  string              name_q[$];
  int                 sent;
  int                 received;

  mdu_top #(.WIDTH(WIDTH)) u_mdu_top (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #50 clk = ~clk;

  // ------------------------------
  // Error reporting and checks
  // ------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_result(input string name, input mdu_fn_e fn,
                              input logic [2*WIDTH-1:0] exp_val,
                              input logic [2*WIDTH-1:0] act_val);
    if (act_val !== exp_val) begin
      stop_on_error($sformatf("Fail %s %s: expected %h, actual %h",
                              name, fn.name(), exp_val, act_val));
    end
  endtask

  task automatic check_flag(input string name, input string what,
                            input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      stop_on_error($sformatf("Fail %s %s: expected %b, actual %b",
                              name, what, exp_val, act_val));
    end
  endtask

  task automatic check_latency(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      stop_on_error($sformatf("Fail %s latency: expected %0d, actual %0d",
                              name, exp_val, act_val));
    end
  endtask

  // Expected {rem, quot} or product; divide by zero gives all-ones quotient magnitude
  function automatic logic [2*WIDTH-1:0] mdu_ref(input mdu_fn_e fn,
                                                 input logic [WIDTH-1:0] a,
                                                 input logic [WIDTH-1:0] b);
    logic signed [2*WIDTH-1:0] sa;
    logic signed [2*WIDTH-1:0] sb;
    logic [2*WIDTH-1:0]        q;
    logic [2*WIDTH-1:0]        r;
    sa = {{WIDTH{a[WIDTH-1]}}, a};
    sb = {{WIDTH{b[WIDTH-1]}}, b};
    q  = '0;
    r  = '0;
    case (fn)
      FN_MUL: return sa * sb;
      FN_DIV, FN_REM: begin
        if (b == '0) begin
          q = {{WIDTH{1'b0}}, {WIDTH{1'b1}}};
          if (a[WIDTH-1]) q = -q;
          r = sa;
        end else begin
          // Truncating division, remainder follows the dividend
          q = sa / sb;
          r = sa % sb;
        end
      end
      FN_DIVU, FN_REMU: begin
        if (b == '0) begin
          q = {{WIDTH{1'b0}}, {WIDTH{1'b1}}};
          r = {{WIDTH{1'b0}}, a};
        end else begin
          q = {{WIDTH{1'b0}}, a / b};
          r = {{WIDTH{1'b0}}, a % b};
        end
      end
      default: q = '0;
    endcase
    return {r[WIDTH-1:0], q[WIDTH-1:0]};
  endfunction

  // ------------------------------
  // One request, latency check, back-pressure, response transfer
  // ------------------------------
  task automatic run_op(input string name, input mdu_fn_e fn,
                        input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    int                 wait_cycles;
    int                 low_cycles;
    int                 hold;
    logic [2*WIDTH-1:0] held;
    mdu_state_e         want_state;
    want_state  = ST_SIGN;
    hold        = $urandom_range(0, 10);
    wait_cycles = 0;
    low_cycles  = 0;
    req_fn  <= fn;
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    do begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT) begin
        stop_on_error($sformatf("Timeout in %s: req_rdy never went high", name));
      end
    end while (!req_rdy);
    // Accepting edge
    req_val <= 1'b0;
    exp_q.push_back(mdu_ref(fn, a, b));
    fn_q.push_back(fn);
    name_q.push_back(name);
    sent++;
    @(posedge clk);
    while (!resp_val) begin
      low_cycles++;
      check_flag(name, "req_rdy while busy", 1'b0, req_rdy);
      if (low_cycles > TIMEOUT) begin
        stop_on_error($sformatf("Timeout in %s: resp_val never went high, FSM never reached %s",
                                name, want_state.name()));
      end
      @(posedge clk);
    end
    check_latency(name, LATENCY, low_cycles);
    held = resp_result;
    repeat (hold) begin
      @(posedge clk);
      check_flag(name, "resp_val under back-pressure", 1'b1, resp_val);
      check_flag(name, "req_rdy under back-pressure", 1'b0, req_rdy);
      check_result({name, " hold"}, fn, held, resp_result);
    end
    resp_rdy <= 1'b1;
    @(posedge clk);
    resp_rdy <= 1'b0;
    // Idle again one cycle after the response transfer
    @(posedge clk);
    check_flag(name, "req_rdy after response", 1'b1, req_rdy);
    check_flag(name, "resp_val after response", 1'b0, resp_val);
  endtask

  // Compare every response on its handshake edge
  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        stop_on_error("A response was transferred with no request outstanding");
      end else begin
        check_result(name_q.pop_front(), fn_q.pop_front(), exp_q.pop_front(), resp_result);
        received++;
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    mdu_fn_e          fn;
    void'($urandom(4));
    clk      = 1'b0;
    reset    = 1'b1;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    sent     = 0;
    received = 0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("reset", "req_rdy", 1'b1, req_rdy);
    check_flag("reset", "resp_val", 1'b0, resp_val);

    run_op("mul_pos_pos", FN_MUL, 32'd1234, 32'd5678);
    run_op("mul_neg_pos", FN_MUL, -32'd77, 32'd1000);
    run_op("mul_neg_neg", FN_MUL, -32'd300000, -32'd9001);
    run_op("mul_max_neg", FN_MUL, 32'h8000_0000, 32'd3);
    run_op("mul_max_neg_sq", FN_MUL, 32'h8000_0000, 32'h8000_0000);
    repeat (50) begin
      a = $urandom();
      b = $urandom();
      run_op("mul_rand", FN_MUL, a, b);
    end

    run_op("div_pos_pos", FN_DIV, 32'd100, 32'd7);
    run_op("div_neg_pos", FN_DIV, -32'd100, 32'd7);
    run_op("rem_pos_neg", FN_REM, 32'd100, -32'd7);
    run_op("rem_neg_neg", FN_REM, -32'd100, -32'd7);
    run_op("div_max_neg", FN_DIV, 32'h8000_0000, -32'd1);
    run_op("divu_big", FN_DIVU, 32'hFFFF_FFFF, 32'd16);
    run_op("remu_small", FN_REMU, 32'd5, 32'd9);

    // Division by zero
    run_op("div_zero_pos", FN_DIV, 32'd12345, 32'd0);
    run_op("rem_zero_neg", FN_REM, -32'd12345, 32'd0);
    run_op("divu_zero", FN_DIVU, 32'hDEAD_BEEF, 32'd0);
    run_op("remu_zero", FN_REMU, 32'd0, 32'd0);

    repeat (60) begin
      fn = mdu_fn_e'($urandom_range(1, 4));
      a  = $urandom();
      b  = $urandom() >> $urandom_range(0, 31);
      if ($urandom_range(0, 1) == 1) b = -b;
      run_op("div_rand", fn, a, b);
    end

    repeat (2) @(posedge clk);
    if ((received == sent) && (exp_q.size() == 0)) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_on_error($sformatf("Only %0d of %0d responses were received", received, sent));
    end
  end

endmodule
